//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // architectural register indices with a fixed role
    localparam reg_addr_t REG_V0 = 5'd2;
    localparam reg_addr_t REG_RA = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of the SPECIAL opcode
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_e;

    // one instruction word seen as R-format or as I-format
    // the J-format target is rs, rt and imm of the I view taken together
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- rtl/reg_port_if.sv
`default_nettype none

// two combinational read ports and one clocked write port
interface reg_port_if;

    mips_pkg::reg_addr_t ra_addr;
    mips_pkg::reg_addr_t rb_addr;
    mips_pkg::word_t     ra_data;
    mips_pkg::word_t     rb_data;

    logic                wr_en;
    mips_pkg::reg_addr_t wr_addr;
    mips_pkg::word_t     wr_data;

    modport control (
        output ra_addr,
        output rb_addr,
        input  ra_data,
        input  rb_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport regfile (
        input  ra_addr,
        input  rb_addr,
        output ra_data,
        output rb_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface

`default_nettype wire

//--- rtl/mips_regfile.sv
`default_nettype none

module mips_regfile (
    input  logic            clk,
    input  logic            rst_n,
    reg_port_if.regfile     regs,
    output mips_pkg::word_t v0
);

    mips_pkg::word_t gpr [32];

    // register zero is cleared at reset and never written, so it always reads zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                gpr[i] <= '0;
            end
        end else if (regs.wr_en && (regs.wr_addr != '0)) begin
            gpr[regs.wr_addr] <= regs.wr_data;
        end
    end

    assign regs.ra_data = gpr[regs.ra_addr];
    assign regs.rb_data = gpr[regs.rb_addr];

    // v0 is tapped for the result port of the CPU
    assign v0 = gpr[mips_pkg::REG_V0];

endmodule

`default_nettype wire

//--- rtl/mips_alu.sv
`default_nettype none

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   result
);

    logic [4:0] shift_amount;

    // shifts move b by the amount carried in the low bits of a
    assign shift_amount = a[4:0];

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            mips_pkg::ALU_SLT: begin
                // signed compare, result is 0 or 1
                result = {31'd0, $signed(a) < $signed(b)};
            end
            mips_pkg::ALU_SLL: begin
                result = b << shift_amount;
            end
            mips_pkg::ALU_SRL: begin
                result = b >> shift_amount;
            end
            mips_pkg::ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mips_control.sv
`default_nettype none

module mips_control #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'h0000_0004
) (
    input  logic              clk,
    input  logic              rst_n,
    reg_port_if.control       regs,
    output mips_pkg::word_t   alu_a,
    output mips_pkg::word_t   alu_b,
    output mips_pkg::alu_op_e alu_op,
    input  mips_pkg::word_t   alu_result,
    output mips_pkg::word_t   address,
    output logic              read,
    output logic              write,
    output mips_pkg::word_t   writedata,
    output logic [3:0]        byteenable,
    input  mips_pkg::word_t   readdata,
    input  logic              waitrequest,
    output logic              active
);

    localparam logic [2:0] ST_FETCH  = 3'd0;
    localparam logic [2:0] ST_DECODE = 3'd1;
    localparam logic [2:0] ST_EXEC   = 3'd2;
    localparam logic [2:0] ST_MEM    = 3'd3;
    localparam logic [2:0] ST_HALT   = 3'd4;

    logic [2:0]       state;
    mips_pkg::word_t  pc;
    mips_pkg::word_t  next_pc;
    logic             in_slot;
    mips_pkg::instr_u ir;
    mips_pkg::word_t  rs_val;
    mips_pkg::word_t  rt_val;
    mips_pkg::word_t  mem_addr;

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic             is_rtype;
    logic             is_shift;
    logic             is_jr;
    logic             is_jalr;
    logic             is_j;
    logic             is_jal;
    logic             is_beq;
    logic             is_bne;
    logic             is_lw;
    logic             is_sw;
    logic             writes_reg;
    logic             taken;
    logic             mem_done;
    logic             retire;
    mips_pkg::word_t  imm_sext;
    mips_pkg::word_t  imm_zext;
    mips_pkg::word_t  target;

    assign opcode   = ir.r_fmt.opcode;
    assign funct    = ir.r_fmt.funct;
    assign is_rtype = (opcode == mips_pkg::OP_SPECIAL);
    assign is_shift = is_rtype && ((funct == mips_pkg::F_SLL) || (funct == mips_pkg::F_SRL));
    assign is_jr    = is_rtype && (funct == mips_pkg::F_JR);
    assign is_jalr  = is_rtype && (funct == mips_pkg::F_JALR);
    assign is_j     = (opcode == mips_pkg::OP_J);
    assign is_jal   = (opcode == mips_pkg::OP_JAL);
    assign is_beq   = (opcode == mips_pkg::OP_BEQ);
    assign is_bne   = (opcode == mips_pkg::OP_BNE);
    assign is_lw    = (opcode == mips_pkg::OP_LW);
    assign is_sw    = (opcode == mips_pkg::OP_SW);
    assign imm_sext = {{16{ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
    assign imm_zext = {16'h0000, ir.i_fmt.imm};

    // ALU operation and whether the instruction writes a register in execute
    always_comb begin
        alu_op     = mips_pkg::ALU_ADD;
        writes_reg = 1'b0;
        if (is_rtype) begin
            writes_reg = 1'b1;
            case (funct)
                mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD;
                mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
                mips_pkg::F_AND:  alu_op = mips_pkg::ALU_AND;
                mips_pkg::F_OR:   alu_op = mips_pkg::ALU_OR;
                mips_pkg::F_XOR:  alu_op = mips_pkg::ALU_XOR;
                mips_pkg::F_SLT:  alu_op = mips_pkg::ALU_SLT;
                mips_pkg::F_SLL:  alu_op = mips_pkg::ALU_SLL;
                mips_pkg::F_SRL:  alu_op = mips_pkg::ALU_SRL;
                mips_pkg::F_JALR: alu_op = mips_pkg::ALU_ADD;
                default:          writes_reg = 1'b0;
            endcase
        end else begin
            case (opcode)
                mips_pkg::OP_ADDIU: writes_reg = 1'b1;
                mips_pkg::OP_ORI: begin
                    alu_op     = mips_pkg::ALU_OR;
                    writes_reg = 1'b1;
                end
                mips_pkg::OP_LUI: begin
                    alu_op     = mips_pkg::ALU_LUI;
                    writes_reg = 1'b1;
                end
                mips_pkg::OP_JAL:   writes_reg = 1'b1;
                default: ;
            endcase
        end
    end

    assign alu_a = is_shift ? {27'd0, ir.r_fmt.shamt} : rs_val;
    assign alu_b = is_rtype ? rt_val :
                   ((opcode == mips_pkg::OP_ORI) || (opcode == mips_pkg::OP_LUI)) ? imm_zext :
                   imm_sext;

    // branch offsets are relative to the delay slot, which is next_pc here
    always_comb begin
        taken  = 1'b0;
        target = next_pc + {imm_sext[29:0], 2'b00};
        if (is_beq) begin
            taken = (rs_val == rt_val);
        end else if (is_bne) begin
            taken = (rs_val != rt_val);
        end else if (is_j || is_jal) begin
            taken  = 1'b1;
            target = {next_pc[31:28], ir.i_fmt.rs, ir.i_fmt.rt, ir.i_fmt.imm, 2'b00};
        end else if (is_jr || is_jalr) begin
            taken  = 1'b1;
            target = rs_val;
        end
    end

    assign mem_done = (state == ST_MEM) && !waitrequest;
    assign retire   = ((state == ST_EXEC) && !is_lw && !is_sw) || mem_done;

    assign regs.ra_addr = ir.r_fmt.rs;
    assign regs.rb_addr = ir.r_fmt.rt;
    assign regs.wr_en   = ((state == ST_EXEC) && writes_reg) || (mem_done && is_lw);
    assign regs.wr_addr = is_jal ? mips_pkg::REG_RA : (is_rtype ? ir.r_fmt.rd : ir.r_fmt.rt);
    // the link address skips the delay slot
    assign regs.wr_data = (state == ST_MEM) ? readdata :
                          (is_jal || is_jalr) ? pc + 32'd8 : alu_result;

    assign address    = (state == ST_FETCH) ? pc : mem_addr;
    // the bus stays idle while reset is held
    assign read       = rst_n && ((state == ST_FETCH) || ((state == ST_MEM) && is_lw));
    assign write      = (state == ST_MEM) && is_sw;
    assign writedata  = rt_val;
    assign byteenable = 4'hf;
    assign active     = (state != ST_HALT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_FETCH;
            pc      <= RESET_VECTOR;
            next_pc <= RESET_VECTOR + 32'd4;
            in_slot <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!waitrequest) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= ST_EXEC;
                ST_EXEC: begin
                    if (is_lw || is_sw) begin
                        state <= ST_MEM;
                    end
                end
                default: ;
            endcase
            // a retiring instruction overrides the state step above
            if (retire) begin
                pc      <= next_pc;
                next_pc <= taken ? target : next_pc + 32'd4;
                in_slot <= taken;
                state   <= (in_slot && (next_pc == '0)) ? ST_HALT : ST_FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_FETCH) && !waitrequest) begin
            ir <= readdata;
        end
        if (state == ST_DECODE) begin
            rs_val <= regs.ra_data;
            rt_val <= regs.rb_data;
        end
        if (state == ST_EXEC) begin
            mem_addr <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_cpu.sv
`default_nettype none

module mips_cpu #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'h0000_0004
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            read,
    output logic            write,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata,
    input  logic            waitrequest
);

    mips_pkg::word_t   alu_a;
    mips_pkg::word_t   alu_b;
    mips_pkg::alu_op_e alu_op;
    mips_pkg::word_t   alu_result;

    reg_port_if regs ();

    mips_control #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .regs       (regs.control),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata),
        .waitrequest(waitrequest),
        .active     (active)
    );

    mips_regfile u_regfile (
        .clk  (clk),
        .rst_n(rst_n),
        .regs (regs.regfile),
        .v0   (register_v0)
    );

    mips_alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result)
    );

endmodule

`default_nettype wire

//--- dv/avalon_ram.sv
`default_nettype none

// word-addressed memory behind an Avalon slave port
// every transfer is held off by a number of wait cycles, fixed or drawn at random
module avalon_ram #(
    parameter int WAIT_CYCLES = 0,
    parameter int MEM_WORDS   = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         random_wait,
    input  mips_pkg::word_t              address,
    input  logic                         read,
    input  logic                         write,
    input  mips_pkg::word_t              writedata,
    input  logic [3:0]                   byteenable,
    output mips_pkg::word_t              readdata,
    output logic                         waitrequest,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  mips_pkg::word_t              load_data
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    mips_pkg::word_t mem [MEM_WORDS];
    int unsigned     cnt;
    int unsigned     wait_now;
    integer          seed;

    initial begin
        seed = 32'hb872;
    end

    assign readdata    = mem[address[ADDR_BITS+1:2]];
    assign waitrequest = (read || write) && (cnt < wait_now);

    // the wait count for the next transfer is drawn when the current one completes
    always @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= 0;
            wait_now <= random_wait ? ($random(seed) & 32'd3) : WAIT_CYCLES;
        end else if (read || write) begin
            if (waitrequest) begin
                cnt <= cnt + 1;
            end else begin
                cnt      <= 0;
                wait_now <= random_wait ? ($random(seed) & 32'd3) : WAIT_CYCLES;
                if (write) begin
                    // only the enabled byte lanes are written
                    for (int i = 0; i < 4; i++) begin
                        if (byteenable[i]) begin
                            mem[address[ADDR_BITS+1:2]][8*i +: 8] <= writedata[8*i +: 8];
                        end
                    end
                end
            end
        end
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

endmodule

`default_nettype wire

//--- dv/mips_props.sv
`default_nettype none

// Avalon master rules checked on the control block
module mips_props (
    input logic            clk,
    input logic            rst_n,
    input logic            read,
    input logic            write,
    input logic            waitrequest,
    input logic            active,
    input mips_pkg::word_t address,
    input mips_pkg::word_t writedata
);

    one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write))
        else $error("read and write asserted together");

    // a stalled request keeps its address, data and direction
    held_request: assert property (@(posedge clk) disable iff (!rst_n)
        ((read || write) && waitrequest) |=>
            ($stable(address) && $stable(writedata)
             && (read == $past(read)) && (write == $past(write))))
        else $error("request changed while waitrequest was high");

    quiet_halt: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> (!read && !write))
        else $error("bus request issued while halted");

endmodule

bind mips_control mips_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .read       (read),
    .write      (write),
    .waitrequest(waitrequest),
    .active     (active),
    .address    (address),
    .writedata  (writedata)
);

`default_nettype wire

//--- dv/tb_mips.sv
`default_nettype none

module tb_mips;

    localparam int              CLK_PERIOD   = 100;
    localparam int              WAIT_CYCLES  = 1;
    localparam int              MAX_WAIT     = 3;
    localparam int              MEM_WORDS    = 256;
    localparam int              ADDR_BITS    = $clog2(MEM_WORDS);
    localparam mips_pkg::word_t RESET_VECTOR = 32'h0000_0004;
    localparam mips_pkg::word_t DATA_BASE    = 32'h0000_0200;
    localparam int              START_WORD   = int'(RESET_VECTOR >> 2);

    // register numbers used by the test programs
    localparam int V0 = 2;
    localparam int T0 = 8;
    localparam int T1 = 9;
    localparam int T2 = 10;
    localparam int T3 = 11;
    localparam int T4 = 12;
    localparam int T5 = 13;
    localparam int T6 = 14;
    localparam int T7 = 15;
    localparam int S0 = 16;
    localparam int S1 = 17;
    localparam int S2 = 18;
    localparam int RA = 31;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 active;
    mips_pkg::word_t      register_v0;
    mips_pkg::word_t      address;
    logic                 read;
    logic                 write;
    mips_pkg::word_t      writedata;
    logic [3:0]           byteenable;
    mips_pkg::word_t      readdata;
    logic                 waitrequest;
    logic                 random_wait;
    logic                 load_en;
    logic [ADDR_BITS-1:0] load_addr;
    mips_pkg::word_t      load_data;

    mips_pkg::word_t prog [MEM_WORDS];
    int              prog_len;
    int              fetches;
    logic            watch_on;
    int              watchdog_cycles;
    int              elapsed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_cpu #(
        .RESET_VECTOR(RESET_VECTOR)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (active),
        .register_v0(register_v0),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata),
        .waitrequest(waitrequest)
    );

    avalon_ram #(
        .WAIT_CYCLES(WAIT_CYCLES),
        .MEM_WORDS  (MEM_WORDS)
    ) ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .random_wait(random_wait),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata),
        .waitrequest(waitrequest),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_strobe(input string name, input logic [3:0] got,
                                input logic [3:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    function automatic mips_pkg::word_t rtype(input logic [5:0] funct, input int rd,
                                              input int rs, input int rt, input int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
    endfunction

    function automatic mips_pkg::word_t itype(input logic [5:0] op, input int rt,
                                              input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic mips_pkg::word_t jtype(input logic [5:0] op, input int target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input mips_pkg::word_t w);
        prog[START_WORD + prog_len] = w;
        prog_len++;
    endtask

    // ISA model of the program image, with delay slots and the halt on a jump to zero
    function automatic void run_reference(output mips_pkg::word_t v0, output int count);
        mips_pkg::word_t mem [MEM_WORDS];
        mips_pkg::word_t gpr [32];
        mips_pkg::word_t pc;
        mips_pkg::word_t npc;
        mips_pkg::word_t tgt;
        mips_pkg::word_t w;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t simm;
        logic            slot;
        logic            taken;
        logic            halt;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = prog[i];
        end
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        pc    = RESET_VECTOR;
        npc   = RESET_VECTOR + 32'd4;
        slot  = 1'b0;
        halt  = 1'b0;
        count = 0;
        while (!halt && (count < 10000)) begin
            w     = mem[pc[ADDR_BITS+1:2]];
            a     = gpr[w[25:21]];
            b     = gpr[w[20:16]];
            simm  = {{16{w[15]}}, w[15:0]};
            taken = 1'b0;
            tgt   = npc + (simm << 2);
            count++;
            case (w[31:26])
                mips_pkg::OP_SPECIAL: begin
                    case (w[5:0])
                        mips_pkg::F_SLL:  gpr[w[15:11]] = b << w[10:6];
                        mips_pkg::F_SRL:  gpr[w[15:11]] = b >> w[10:6];
                        mips_pkg::F_ADDU: gpr[w[15:11]] = a + b;
                        mips_pkg::F_SUBU: gpr[w[15:11]] = a - b;
                        mips_pkg::F_AND:  gpr[w[15:11]] = a & b;
                        mips_pkg::F_OR:   gpr[w[15:11]] = a | b;
                        mips_pkg::F_XOR:  gpr[w[15:11]] = a ^ b;
                        mips_pkg::F_SLT:  gpr[w[15:11]] = {31'd0, $signed(a) < $signed(b)};
                        mips_pkg::F_JR: begin
                            taken = 1'b1;
                            tgt   = a;
                        end
                        mips_pkg::F_JALR: begin
                            taken         = 1'b1;
                            tgt           = a;
                            gpr[w[15:11]] = pc + 32'd8;
                        end
                        default: ;
                    endcase
                end
                mips_pkg::OP_J: begin
                    taken = 1'b1;
                    tgt   = {npc[31:28], w[25:0], 2'b00};
                end
                mips_pkg::OP_JAL: begin
                    taken   = 1'b1;
                    tgt     = {npc[31:28], w[25:0], 2'b00};
                    gpr[RA] = pc + 32'd8;
                end
                mips_pkg::OP_BEQ:   taken = (a == b);
                mips_pkg::OP_BNE:   taken = (a != b);
                mips_pkg::OP_ADDIU: gpr[w[20:16]] = a + simm;
                mips_pkg::OP_ORI:   gpr[w[20:16]] = a | {16'h0000, w[15:0]};
                mips_pkg::OP_LUI:   gpr[w[20:16]] = {w[15:0], 16'h0000};
                mips_pkg::OP_LW:    gpr[w[20:16]] = mem[(a + simm) >> 2];
                mips_pkg::OP_SW:    mem[(a + simm) >> 2] = b;
                default: ;
            endcase
            gpr[0] = '0;
            halt   = slot && (npc == 32'd0);
            pc     = npc;
            npc    = taken ? tgt : npc + 32'd4;
            slot   = taken;
        end
        v0 = gpr[V0];
    endfunction

    task automatic build_program(input int test);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = '0;
        end
        prog_len = 0;
        case (test)
            0: begin
                // call through JALR, return by JR ra, then JR to zero
                emit(itype(mips_pkg::OP_ADDIU, T0, 0, 32'h1c));
                emit(rtype(mips_pkg::F_JALR, RA, T0, 0, 0));
                emit(itype(mips_pkg::OP_ADDIU, V0, 0, 5));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 7));
                emit(rtype(mips_pkg::F_JR, 0, 0, 0, 0));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 1));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 100));
                emit(rtype(mips_pkg::F_JR, 0, RA, 0, 0));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 3));
            end
            1: begin
                emit(itype(mips_pkg::OP_ADDIU, T0, 0, -5));
                emit(itype(mips_pkg::OP_ADDIU, T1, 0, 3));
                emit(rtype(mips_pkg::F_ADDU, T2, T0, T1, 0));
                emit(rtype(mips_pkg::F_SUBU, T3, T1, T0, 0));
                emit(rtype(mips_pkg::F_SLT, T4, T0, T1, 0));
                emit(rtype(mips_pkg::F_AND, T5, T2, T3, 0));
                emit(rtype(mips_pkg::F_OR, T6, T5, T4, 0));
                emit(rtype(mips_pkg::F_XOR, T7, T6, T0, 0));
                emit(itype(mips_pkg::OP_LUI, S0, 0, 32'h1234));
                emit(itype(mips_pkg::OP_ORI, S0, S0, 32'h8765));
                emit(rtype(mips_pkg::F_SLL, S1, 0, T7, 4));
                emit(rtype(mips_pkg::F_SRL, S2, 0, S0, 3));
                emit(rtype(mips_pkg::F_ADDU, V0, S1, S2, 0));
                emit(rtype(mips_pkg::F_XOR, V0, V0, T4, 0));
                emit(rtype(mips_pkg::F_ADDU, V0, V0, T3, 0));
                emit(rtype(mips_pkg::F_JR, 0, 0, 0, 0));
                emit(rtype(mips_pkg::F_SLL, 0, 0, 0, 0));
            end
            2: begin
                // one data word is preloaded behind the three that are stored
                prog[(DATA_BASE >> 2) + 3] = 32'h0000_1000;
                emit(itype(mips_pkg::OP_ADDIU, S0, 0, int'(DATA_BASE)));
                emit(itype(mips_pkg::OP_ADDIU, T0, 0, 32'h11));
                emit(itype(mips_pkg::OP_LUI, T1, 0, 32'habcd));
                emit(itype(mips_pkg::OP_ORI, T1, T1, 32'h0123));
                emit(itype(mips_pkg::OP_ADDIU, T2, 0, -7));
                emit(itype(mips_pkg::OP_SW, T0, S0, 0));
                emit(itype(mips_pkg::OP_SW, T1, S0, 4));
                emit(itype(mips_pkg::OP_SW, T2, S0, 8));
                emit(itype(mips_pkg::OP_LW, T3, S0, 8));
                emit(itype(mips_pkg::OP_LW, T4, S0, 0));
                emit(itype(mips_pkg::OP_LW, T5, S0, 4));
                emit(itype(mips_pkg::OP_LW, T6, S0, 12));
                emit(rtype(mips_pkg::F_ADDU, V0, T3, T4, 0));
                emit(rtype(mips_pkg::F_ADDU, V0, V0, T5, 0));
                emit(rtype(mips_pkg::F_ADDU, V0, V0, T6, 0));
                emit(rtype(mips_pkg::F_JR, 0, 0, 0, 0));
                emit(rtype(mips_pkg::F_SLL, 0, 0, 0, 0));
            end
            default: begin
                // loop at 0x0c calls the routine at 0x24, exit through BEQ to 0x30
                emit(itype(mips_pkg::OP_ADDIU, T0, 0, 5));
                emit(itype(mips_pkg::OP_ADDIU, V0, 0, 0));
                emit(jtype(mips_pkg::OP_JAL, 32'h24));
                emit(itype(mips_pkg::OP_ADDIU, T0, T0, -1));
                emit(itype(mips_pkg::OP_BNE, 0, T0, -3));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 1));
                emit(itype(mips_pkg::OP_BEQ, 0, 0, 4));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 32'h10));
                emit(rtype(mips_pkg::F_ADDU, V0, V0, T0, 0));
                emit(rtype(mips_pkg::F_JR, 0, RA, 0, 0));
                emit(rtype(mips_pkg::F_SLL, 0, 0, 0, 0));
                emit(jtype(mips_pkg::OP_J, 0));
                emit(itype(mips_pkg::OP_ADDIU, V0, V0, 2));
            end
        endcase
    endtask

    // instructions live below DATA_BASE, so reads there are fetches
    always @(posedge clk) begin
        if (!rst_n) begin
            fetches <= 0;
        end else if ((read || write) && !waitrequest) begin
            check_strobe("byteenable", byteenable, 4'hf);
            if (read && (address < DATA_BASE)) begin
                fetches <= fetches + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!watch_on) begin
            elapsed <= 0;
        end else if (elapsed >= watchdog_cycles) begin
            $display("active never fell within %0d cycles", watchdog_cycles);
            fail_run();
        end else begin
            elapsed <= elapsed + 1;
        end
    end

    task automatic run_program(input logic with_random_wait);
        mips_pkg::word_t exp_v0;
        int              exp_count;
        @(negedge clk);
        rst_n       = 1'b0;
        random_wait = with_random_wait;
        for (int i = 0; i < MEM_WORDS; i++) begin
            load_en   = 1'b1;
            load_addr = i[ADDR_BITS-1:0];
            load_data = prog[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag("read", read, 1'b0);
        end
        watchdog_cycles = prog_len * (4 + 2 * MAX_WAIT) * 20;
        watch_on        = 1'b1;
        rst_n           = 1'b1;
        while (active) begin
            @(negedge clk);
        end
        watch_on = 1'b0;
        run_reference(exp_v0, exp_count);
        check_word("register_v0", register_v0, exp_v0);
        check_count("fetch count", fetches, exp_count);
        repeat (20) begin
            @(negedge clk);
            check_flag("active", active, 1'b0);
            check_flag("read", read, 1'b0);
            check_flag("write", write, 1'b0);
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        random_wait     = 1'b0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        watch_on        = 1'b0;
        watchdog_cycles = 0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int test = 0; test < 4; test++) begin
                build_program(test);
                run_program(pass == 1);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
rtl/mips_pkg.sv
rtl/reg_port_if.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_control.sv
rtl/mips_cpu.sv
dv/avalon_ram.sv
dv/mips_props.sv
dv/tb_mips.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log

SOURCES := $(shell cat compile.f)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): compile.f $(SOURCES)
	$(VERILATOR) --binary --assert -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
